// File: audio_out/i2s_tx.sv
// I2S transmitter: control and sample registers with bit clock, frame clock and serializer
`timescale 1ns/1ps
`include "n4_sys_config.svh"

module i2s_tx import n4_sys_pkg::*; (
	input  logic       cpu_clk,
	input  logic       rst,
	input  logic       cs_i,
	input  bus_req_t   req_i,
	output slave_rsp_t rsp_o,
	output logic       ac_bclk_o,
	output logic       ac_lrclk_o,
	output logic       ac_clk_oe_o,
	output logic       ac_dac_sdata_o
);

	localparam int DIV_W = $clog2(`AUD_BCLK_DIV);

	logic             en_tx_q;
	logic             en_rx_q;
	logic [15:0]      left_q;
	logic [15:0]      right_q;
	logic             ack_q;
	logic             first;
	logic [DIV_W-1:0] div_cnt;
	logic [5:0]       bit_cnt;
	logic [63:0]      shift_q;
	logic             bclk_fall;

	// ====================
	// Register file
	// ====================

	assign first = cs_i & req_i.stb & ~ack_q;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_q   <= 1'b0;
			en_tx_q <= 1'b0;
			en_rx_q <= 1'b0;
			left_q  <= '0;
			right_q <= '0;
		end else begin
			ack_q <= cs_i & req_i.stb;
			if (first && req_i.we) begin
				case (req_i.addr[2:1])
					2'd0: begin
						en_tx_q <= req_i.wdata[1];
						en_rx_q <= req_i.wdata[0];
					end
					2'd1: left_q  <= req_i.wdata;
					2'd2: right_q <= req_i.wdata;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (req_i.addr[2:1])
			2'd0:    rsp_o.rdata = {14'h0, en_tx_q, en_rx_q};
			2'd1:    rsp_o.rdata = left_q;
			2'd2:    rsp_o.rdata = right_q;
			default: rsp_o.rdata = '0;
		endcase
	end

	assign rsp_o.ack = ack_q;

	// ====================
	// Serializer
	// ====================

	// Bit clock low for the first half of each period
	assign bclk_fall = (div_cnt == DIV_W'(`AUD_BCLK_DIV - 1));

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			div_cnt <= '0;
			bit_cnt <= '0;
			shift_q <= '0;
		end else begin
			div_cnt <= bclk_fall ? '0 : div_cnt + 1'b1;
			if (bclk_fall) begin
				bit_cnt <= bit_cnt + 1'b1;
				// Each half is one idle slot, the sample MSB first, then zeros
				if (bit_cnt == 6'd63) begin
					shift_q <= {1'b0, left_q, 15'h0, 1'b0, right_q, 15'h0};
				end else begin
					shift_q <= {shift_q[62:0], 1'b0};
				end
			end
		end
	end

	assign ac_bclk_o      = (div_cnt >= DIV_W'(`AUD_BCLK_DIV / 2));
	assign ac_lrclk_o     = bit_cnt[5];
	assign ac_clk_oe_o    = en_tx_q | en_rx_q;
	assign ac_dac_sdata_o = en_tx_q & shift_q[63];

endmodule

// File: common/n4_sys_config.svh
// n4_sys configuration: address map, stack RAM sizing, wait states and audio timing
`ifndef N4_SYS_CONFIG_SVH
`define N4_SYS_CONFIG_SVH

// ====================
// Address map
// ====================

// Stack RAM decodes on the top 12 address bits
`define STACK_BASE_HI 12'hFF4

// I/O blocks decode on the top 28 address bits
`define LED_BASE      28'hFFDC060
`define RAND_BASE     28'hFFDC0C0
`define AUDIO_BASE    28'hFFDC070

// Returned for reads that hit no slave
`define UNMAPPED_DATA 16'hFFFF

// ====================
// Stack RAM
// ====================

// Depth in 16-bit words
`define STACK_WORDS   1024

// Cycles from strobe to acknowledge
`define STACK_WAIT    3

// ====================
// Audio
// ====================

// cpu_clk cycles per I2S bit clock
`define AUD_BCLK_DIV  4

`endif

// File: common/n4_sys_pkg.sv
// n4_sys shared types: internal bus request, slave response and decoded region
package n4_sys_pkg;

	// ====================
	// Bus request
	// ====================

	// One request is broadcast to every slave
	typedef struct packed {
		logic [31:0] addr;
		logic [15:0] wdata;
		// Bit 1 is the upper byte lane
		logic [1:0]  sel;
		logic        we;
		logic        stb;
	} bus_req_t;

	// ====================
	// Slave response
	// ====================

	// ack stays high while cs and stb are held
	typedef struct packed {
		logic        ack;
		logic [15:0] rdata;
	} slave_rsp_t;

	// ====================
	// Decoded target
	// ====================

	typedef enum logic [2:0] {
		REG_NONE,
		REG_STACK,
		REG_LED,
		REG_RAND,
		REG_AUDIO
	} region_e;

endpackage

// File: n4_sys.f
+incdir+common
+incdir+testbench
common/n4_sys_pkg.sv
src/bus_decode.sv
stack_ram/stack_ram.sv
src/led_port.sv
src/rand_gen.sv
audio_out/i2s_tx.sv
src/n4_sys.sv
testbench/n4_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile n4_sys with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module n4_sys_tb \
	-f n4_sys.f -o n4_sys_sim

./obj_dir/n4_sys_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

// File: src/bus_decode.sv
// Bus decoder: turns CPU strobes into a request, selects the slave and merges responses
`timescale 1ns/1ps
`include "n4_sys_config.svh"

module bus_decode import n4_sys_pkg::*; (
	input  logic        cpu_clk,
	input  logic        rst,
	input  logic        cpu_as_n_i,
	input  logic        cpu_uds_n_i,
	input  logic        cpu_lds_n_i,
	input  logic        cpu_r_w_i,
	input  logic [31:0] cpu_addr_i,
	input  logic [15:0] cpu_data_i,
	output logic [15:0] cpu_data_o,
	output logic        cpu_dtack_n_o,
	output bus_req_t    req_o,
	output logic        cs_stack_o,
	output logic        cs_led_o,
	output logic        cs_rand_o,
	output logic        cs_audio_o,
	input  slave_rsp_t  stack_rsp_i,
	input  slave_rsp_t  led_rsp_i,
	input  slave_rsp_t  rand_rsp_i,
	input  slave_rsp_t  audio_rsp_i
);

	region_e    region;
	slave_rsp_t sel_rsp;
	logic       stb;
	logic       unmapped_ack_q;

	// Address strobe plus at least one data strobe
	assign stb = ~cpu_as_n_i & ~(cpu_uds_n_i & cpu_lds_n_i);

	assign req_o.addr  = cpu_addr_i;
	assign req_o.wdata = cpu_data_i;
	assign req_o.sel   = ~{cpu_uds_n_i, cpu_lds_n_i};
	assign req_o.we    = ~cpu_r_w_i;
	assign req_o.stb   = stb;

	// ====================
	// Region decode
	// ====================

	always_comb begin
		if (cpu_addr_i[31:20] == `STACK_BASE_HI) begin
			region = REG_STACK;
		end else if (cpu_addr_i[31:4] == `LED_BASE) begin
			region = REG_LED;
		end else if (cpu_addr_i[31:4] == `RAND_BASE) begin
			region = REG_RAND;
		end else if (cpu_addr_i[31:4] == `AUDIO_BASE) begin
			region = REG_AUDIO;
		end else begin
			region = REG_NONE;
		end
	end

	assign cs_stack_o = (region == REG_STACK);
	assign cs_led_o   = (region == REG_LED);
	assign cs_rand_o  = (region == REG_RAND);
	assign cs_audio_o = (region == REG_AUDIO);

	// Nobody else answers unmapped cycles
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			unmapped_ack_q <= 1'b0;
		end else begin
			unmapped_ack_q <= (region == REG_NONE) & stb;
		end
	end

	// ====================
	// Response merge
	// ====================

	always_comb begin
		case (region)
			REG_STACK: sel_rsp = stack_rsp_i;
			REG_LED:   sel_rsp = led_rsp_i;
			REG_RAND:  sel_rsp = rand_rsp_i;
			REG_AUDIO: sel_rsp = audio_rsp_i;
			default: begin
				sel_rsp.ack   = unmapped_ack_q;
				sel_rsp.rdata = `UNMAPPED_DATA;
			end
		endcase
	end

	assign cpu_data_o    = sel_rsp.rdata;
	assign cpu_dtack_n_o = ~sel_rsp.ack;

endmodule

// File: src/led_port.sv
// LED and switch port: LED register, switch read-back and button-selected address view
`timescale 1ns/1ps

module led_port import n4_sys_pkg::*; (
	input  logic       cpu_clk,
	input  logic       rst,
	input  logic       cs_i,
	input  bus_req_t   req_i,
	output slave_rsp_t rsp_o,
	input  logic [7:0] sw_i,
	input  logic       btn_d_i,
	input  logic       btn_r_i,
	input  logic       btn_l_i,
	output logic [7:0] led_o
);

	logic [7:0]  led_q;
	logic [31:0] addr_q;
	logic        ack_q;
	logic        active;

	assign active = cs_i & req_i.stb;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_q  <= 1'b0;
			led_q  <= '0;
			addr_q <= '0;
		end else begin
			ack_q <= active;
			if (active && !ack_q && req_i.we) begin
				led_q <= req_i.wdata[7:0];
			end
			// Any strobed cycle, not just ours
			if (req_i.stb) begin
				addr_q <= req_i.addr;
			end
		end
	end

	assign rsp_o.ack   = ack_q;
	assign rsp_o.rdata = {8'h00, sw_i};

	// Buttons override the LED register, d first
	assign led_o = btn_d_i ? addr_q[23:16] :
	               btn_r_i ? addr_q[15:8]  :
	               btn_l_i ? addr_q[7:0]   :
	               led_q;

endmodule

// File: src/n4_sys.sv
// n4_sys top level: bus decoder with stack RAM, LED port, random generator and I2S output
`timescale 1ns/1ps

module n4_sys import n4_sys_pkg::*; (
	input  logic        cpu_clk,
	input  logic        rst,
	// 68000-style CPU bus
	input  logic        cpu_as_n_i,
	input  logic        cpu_uds_n_i,
	input  logic        cpu_lds_n_i,
	input  logic        cpu_r_w_i,
	input  logic [31:0] cpu_addr_i,
	input  logic [15:0] cpu_data_i,
	output logic [15:0] cpu_data_o,
	output logic        cpu_dtack_n_o,
	// Board I/O
	input  logic [7:0]  sw_i,
	input  logic        btn_d_i,
	input  logic        btn_r_i,
	input  logic        btn_l_i,
	output logic [7:0]  led_o,
	// Audio codec
	output logic        ac_bclk_o,
	output logic        ac_lrclk_o,
	output logic        ac_clk_oe_o,
	output logic        ac_dac_sdata_o
);

	bus_req_t   req;
	slave_rsp_t stack_rsp;
	slave_rsp_t led_rsp;
	slave_rsp_t rand_rsp;
	slave_rsp_t audio_rsp;
	logic       cs_stack;
	logic       cs_led;
	logic       cs_rand;
	logic       cs_audio;

	bus_decode bus_decode_inst (
		.cpu_clk       (cpu_clk),
		.rst           (rst),
		.cpu_as_n_i    (cpu_as_n_i),
		.cpu_uds_n_i   (cpu_uds_n_i),
		.cpu_lds_n_i   (cpu_lds_n_i),
		.cpu_r_w_i     (cpu_r_w_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_data_i    (cpu_data_i),
		.cpu_data_o    (cpu_data_o),
		.cpu_dtack_n_o (cpu_dtack_n_o),
		.req_o         (req),
		.cs_stack_o    (cs_stack),
		.cs_led_o      (cs_led),
		.cs_rand_o     (cs_rand),
		.cs_audio_o    (cs_audio),
		.stack_rsp_i   (stack_rsp),
		.led_rsp_i     (led_rsp),
		.rand_rsp_i    (rand_rsp),
		.audio_rsp_i   (audio_rsp)
	);

	stack_ram stack_ram_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_stack),
		.req_i   (req),
		.rsp_o   (stack_rsp)
	);

	led_port led_port_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_led),
		.req_i   (req),
		.rsp_o   (led_rsp),
		.sw_i    (sw_i),
		.btn_d_i (btn_d_i),
		.btn_r_i (btn_r_i),
		.btn_l_i (btn_l_i),
		.led_o   (led_o)
	);

	rand_gen rand_gen_inst (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.cs_i    (cs_rand),
		.req_i   (req),
		.rsp_o   (rand_rsp)
	);

	i2s_tx i2s_tx_inst (
		.cpu_clk        (cpu_clk),
		.rst            (rst),
		.cs_i           (cs_audio),
		.req_i          (req),
		.rsp_o          (audio_rsp),
		.ac_bclk_o      (ac_bclk_o),
		.ac_lrclk_o     (ac_lrclk_o),
		.ac_clk_oe_o    (ac_clk_oe_o),
		.ac_dac_sdata_o (ac_dac_sdata_o)
	);

endmodule

// File: src/rand_gen.sv
// Random number generator: seedable 32-bit Galois LFSR read as two 16-bit halves
`timescale 1ns/1ps

module rand_gen import n4_sys_pkg::*; (
	input  logic       cpu_clk,
	input  logic       rst,
	input  logic       cs_i,
	input  bus_req_t   req_i,
	output slave_rsp_t rsp_o
);

	localparam logic [31:0] TAP_MASK = 32'h8020_0003;

	logic [31:0] state_q;
	logic [15:0] rdata_q;
	logic        ack_q;
	logic        first;
	logic        hi_half;

	// One Galois shift, zero state escapes to 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		if (s == '0) begin
			n = 32'h1;
		end else if (s[0]) begin
			n = (s >> 1) ^ TAP_MASK;
		end else begin
			n = s >> 1;
		end
		return n;
	endfunction

	assign first   = cs_i & req_i.stb & ~ack_q;
	assign hi_half = req_i.addr[1];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			ack_q   <= 1'b0;
			state_q <= 32'h1;
		end else begin
			ack_q <= cs_i & req_i.stb;
			if (first && req_i.we) begin
				if (hi_half) begin
					state_q[31:16] <= req_i.wdata;
				end else begin
					state_q[15:0] <= req_i.wdata;
				end
			end else if (first && !hi_half) begin
				// Low-half read consumes a value
				state_q <= lfsr_step(state_q);
			end
		end
	end

	// Read data captured before the step, held through ack
	always_ff @(posedge cpu_clk) begin
		if (first) begin
			rdata_q <= hi_half ? state_q[31:16] : state_q[15:0];
		end
	end

	assign rsp_o.ack   = ack_q;
	assign rsp_o.rdata = rdata_q;

endmodule

// File: stack_ram/stack_ram.sv
// Stack RAM: byte-lane writable word memory answering after a fixed number of wait states
`timescale 1ns/1ps
`include "n4_sys_config.svh"

module stack_ram import n4_sys_pkg::*; (
	input  logic       cpu_clk,
	input  logic       rst,
	input  logic       cs_i,
	input  bus_req_t   req_i,
	output slave_rsp_t rsp_o
);

	localparam int AW    = $clog2(`STACK_WORDS);
	localparam int CNT_W = $clog2(`STACK_WAIT) + 1;

	logic [1:0][7:0]  mem [`STACK_WORDS];
	logic [AW-1:0]    idx;
	logic [15:0]      rdata_q;
	logic [CNT_W-1:0] wait_cnt;
	logic             ack_q;
	logic             active;
	logic             ack_set;

	// Word index, address bit 0 picks the byte only
	assign idx     = req_i.addr[AW:1];
	assign active  = cs_i & req_i.stb;
	assign ack_set = active & ~ack_q & (wait_cnt == CNT_W'(`STACK_WAIT - 1));

	// Wait-state counter, restarts whenever the strobe goes away
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			wait_cnt <= '0;
			ack_q    <= 1'b0;
		end else if (!active) begin
			wait_cnt <= '0;
			ack_q    <= 1'b0;
		end else if (ack_set) begin
			ack_q <= 1'b1;
		end else if (!ack_q) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Write lands once, on the edge that raises ack
	always_ff @(posedge cpu_clk) begin
		if (ack_set && req_i.we) begin
			if (req_i.sel[1]) begin
				mem[idx][1] <= req_i.wdata[15:8];
			end
			if (req_i.sel[0]) begin
				mem[idx][0] <= req_i.wdata[7:0];
			end
		end
		rdata_q <= mem[idx];
	end

	assign rsp_o.ack   = ack_q;
	assign rsp_o.rdata = rdata_q;

endmodule

// File: testbench/n4_sys_tb_tasks.svh
// n4_sys testbench helpers: CPU bus cycles plus LFSR and I2S reference models
`ifndef N4_SYS_TB_TASKS_SVH
`define N4_SYS_TB_TASKS_SVH

// ====================
// Bus master
// ====================

// One CPU cycle, strobe held for hold extra cycles after data acknowledge
task automatic bus_cycle(
	input  logic [31:0] addr,
	input  logic        we,
	input  logic [1:0]  sel,
	input  logic [15:0] wdata,
	input  int          hold,
	output logic [15:0] rdata,
	output int          latency
);
	int   waited;
	logic acked;
	waited = 0;
	acked  = 1'b0;
	@(posedge cpu_clk);
	#1;
	cpu_addr_i  = addr;
	cpu_data_i  = wdata;
	cpu_r_w_i   = ~we;
	cpu_uds_n_i = ~sel[1];
	cpu_lds_n_i = ~sel[0];
	cpu_as_n_i  = 1'b0;
	// Edges counted from the first one that samples the strobe
	while (!acked && waited < ACK_LIMIT) begin
		@(posedge cpu_clk);
		#1;
		waited++;
		acked = ~cpu_dtack_n_o;
	end
	rdata   = cpu_data_o;
	latency = waited;
	if (!acked) begin
		$display("ERROR %s: no data acknowledge from address %h within %0d cycles",
			test_name, addr, ACK_LIMIT);
		error_count++;
	end
	// Data bus flips while held, so a second write would land a different value
	repeat (hold) begin
		@(posedge cpu_clk);
		#1;
		cpu_data_i = ~wdata;
	end
	cpu_as_n_i  = 1'b1;
	cpu_uds_n_i = 1'b1;
	cpu_lds_n_i = 1'b1;
	cpu_r_w_i   = 1'b1;
endtask

// Byte address of a stack RAM word
function automatic logic [31:0] stack_addr(input int idx);
	return {`STACK_BASE_HI, 20'(idx * 2)};
endfunction

// ====================
// Reference models
// ====================

// Galois LFSR with taps 80200003, an all-zero state recovers to 1
function automatic logic [31:0] lfsr_model(input logic [31:0] s);
	logic [31:0] nxt;
	nxt = {1'b0, s[31:1]};
	if (s[0]) begin
		nxt = nxt ^ 32'h8020_0003;
	end
	if (s == 32'h0) begin
		nxt = 32'h1;
	end
	return nxt;
endfunction

// Frame slot 0..63: one idle slot, then the sample MSB first, then zeros
function automatic logic i2s_bit(input int slot, input logic [15:0] l_smp,
		input logic [15:0] r_smp);
	int          pos;
	logic [15:0] smp;
	pos = slot % 32;
	smp = (slot < 32) ? l_smp : r_smp;
	if (pos >= 1 && pos <= 16) begin
		return smp[16 - pos];
	end
	return 1'b0;
endfunction

`endif

// File: testbench/n4_sys_tb.sv
// n4_sys testbench: plays the CPU bus master and checks each slave against reference models
`timescale 1ns/1ps
`include "n4_sys_config.svh"

module n4_sys_tb;

	// Audio frame alignment and capture dominate the roughly 2000 cycles of tests
	localparam int RUN_LIMIT   = 6000;
	localparam int ACK_LIMIT   = 16;
	localparam int STACK_TRIES = 8;
	localparam int RAND_READS  = 8;
	localparam logic [31:0] LED_ADDR   = {`LED_BASE, 4'h0};
	localparam logic [31:0] RAND_ADDR  = {`RAND_BASE, 4'h0};
	localparam logic [31:0] AUDIO_ADDR = {`AUDIO_BASE, 4'h0};

	logic        cpu_clk;
	logic        rst;
	logic        cpu_as_n_i;
	logic        cpu_uds_n_i;
	logic        cpu_lds_n_i;
	logic        cpu_r_w_i;
	logic [31:0] cpu_addr_i;
	logic [15:0] cpu_data_i;
	logic [15:0] cpu_data_o;
	logic        cpu_dtack_n_o;
	logic [7:0]  sw_i;
	logic [7:0]  led_o;
	logic        btn_d_i;
	logic        btn_r_i;
	logic        btn_l_i;
	logic        ac_bclk_o;
	logic        ac_lrclk_o;
	logic        ac_clk_oe_o;
	logic        ac_dac_sdata_o;

	int    seed;
	int    cycle_count;
	int    error_count;
	int    check_count;
	int    tests_run;
	int    tests_failed;
	int    errors_before;
	string test_name;

	logic [15:0] stack_model [`STACK_WORDS];
	int          idx_list [STACK_TRIES];
	int          i;
	int          lat;
	logic [15:0] rd;
	logic [15:0] data;
	logic [15:0] left;
	logic [15:0] right;
	logic [1:0]  sel;
	logic [31:0] addr;
	logic [31:0] lfsr_state;

	`include "n4_sys_tb_tasks.svh"

	n4_sys n4_sys_inst (.*);

	always #2 cpu_clk = ~cpu_clk;

	always @(posedge cpu_clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= RUN_LIMIT);
		$display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check_eq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s: expected %h actual %h",
				test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		errors_before = error_count;
	endtask

	task automatic finish_test();
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, error_count - errors_before);
		end
	endtask

	task automatic set_buttons(input logic d, input logic r, input logic l);
		@(posedge cpu_clk);
		#1;
		btn_d_i = d;
		btn_r_i = r;
		btn_l_i = l;
		@(negedge cpu_clk);
	endtask

	// Waits for the left half to start and checks all 64 slots on bit clock rises
	task automatic check_frame(input logic [15:0] l_smp, input logic [15:0] r_smp,
			input logic tx_on);
		logic lr_prev;
		logic bclk_prev;
		int   slot;
		int   gap;
		lr_prev = 1'b0;
		while (!(lr_prev && !ac_lrclk_o)) begin
			lr_prev = ac_lrclk_o;
			@(negedge cpu_clk);
		end
		bclk_prev = ac_bclk_o;
		slot      = 0;
		gap       = 0;
		while (slot < 64) begin
			@(negedge cpu_clk);
			gap++;
			if (ac_bclk_o && !bclk_prev) begin
				// Rise to rise spacing of the bit clock
				if (slot > 0) begin
					check_eq("bclk period", `AUD_BCLK_DIV, gap);
				end
				check_eq("lrclk", slot >= 32, ac_lrclk_o);
				check_eq("sdata", tx_on & i2s_bit(slot, l_smp, r_smp), ac_dac_sdata_o);
				slot++;
				gap = 0;
			end
			bclk_prev = ac_bclk_o;
		end
	endtask

	initial begin
		seed         = 9;
		cycle_count  = 0;
		error_count  = 0;
		check_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		cpu_clk      = 1'b0;
		rst          = 1'b1;
		cpu_as_n_i   = 1'b1;
		cpu_uds_n_i  = 1'b1;
		cpu_lds_n_i  = 1'b1;
		cpu_r_w_i    = 1'b1;
		cpu_addr_i   = '0;
		cpu_data_i   = '0;
		sw_i         = '0;
		btn_d_i      = 1'b0;
		btn_r_i      = 1'b0;
		btn_l_i      = 1'b0;
		repeat (5) @(posedge cpu_clk);
		#1;
		rst = 1'b0;

		start_test("reset");
		@(negedge cpu_clk);
		check_eq("dtack_n", 1, cpu_dtack_n_o);
		check_eq("led_o", 0, led_o);
		check_eq("clock enable", 0, ac_clk_oe_o);
		check_eq("sdata", 0, ac_dac_sdata_o);
		finish_test();

		// ====================
		// LED port
		// ====================
		start_test("led");
		data = 16'($random(seed));
		bus_cycle(LED_ADDR, 1'b1, 2'b11, data, 0, rd, lat);
		check_eq("led byte", data[7:0], led_o);
		check_eq("ack latency", 1, lat);
		sw_i = 8'($random(seed));
		bus_cycle(LED_ADDR, 1'b0, 2'b11, 16'h0, 0, rd, lat);
		check_eq("switch read", {8'h00, sw_i}, rd);
		// Any strobed address feeds the button views
		addr = {8'h00, 24'($random(seed))};
		bus_cycle(addr, 1'b0, 2'b11, 16'h0, 0, rd, lat);
		set_buttons(1'b1, 1'b0, 1'b0);
		check_eq("button d", addr[23:16], led_o);
		set_buttons(1'b0, 1'b1, 1'b0);
		check_eq("button r", addr[15:8], led_o);
		set_buttons(1'b0, 1'b0, 1'b1);
		check_eq("button l", addr[7:0], led_o);
		set_buttons(1'b1, 1'b1, 1'b1);
		check_eq("button priority", addr[23:16], led_o);
		set_buttons(1'b0, 1'b0, 1'b0);
		check_eq("led restored", data[7:0], led_o);
		finish_test();

		// ====================
		// Stack RAM
		// ====================
		start_test("stack");
		for (i = 0; i < STACK_TRIES; i++) begin
			idx_list[i] = $random(seed) & (`STACK_WORDS - 1);
			data        = 16'($random(seed));
			bus_cycle(stack_addr(idx_list[i]), 1'b1, 2'b11, data, 0, rd, lat);
			stack_model[idx_list[i]] = data;
			check_eq("write wait states", `STACK_WAIT, lat);
		end
		// Single lanes over the words just written
		for (i = 0; i < STACK_TRIES; i++) begin
			data = 16'($random(seed));
			sel  = ($random(seed) & 1) ? 2'b10 : 2'b01;
			bus_cycle(stack_addr(idx_list[i]), 1'b1, sel, data, 0, rd, lat);
			if (sel[1]) begin
				stack_model[idx_list[i]][15:8] = data[15:8];
			end
			if (sel[0]) begin
				stack_model[idx_list[i]][7:0] = data[7:0];
			end
		end
		for (i = 0; i < STACK_TRIES; i++) begin
			bus_cycle(stack_addr(idx_list[i]), 1'b0, 2'b11, 16'h0, 0, rd, lat);
			check_eq("merged read", stack_model[idx_list[i]], rd);
			check_eq("read wait states", `STACK_WAIT, lat);
		end
		data = 16'($random(seed));
		bus_cycle(stack_addr(idx_list[0]), 1'b1, 2'b11, data, 3, rd, lat);
		bus_cycle(stack_addr(idx_list[0]), 1'b0, 2'b11, 16'h0, 0, rd, lat);
		check_eq("held write", data, rd);
		finish_test();

		// ====================
		// Random generator
		// ====================
		start_test("rand");
		lfsr_state = $random(seed);
		bus_cycle(RAND_ADDR + 2, 1'b1, 2'b11, lfsr_state[31:16], 0, rd, lat);
		bus_cycle(RAND_ADDR, 1'b1, 2'b11, lfsr_state[15:0], 0, rd, lat);
		for (i = 0; i < RAND_READS; i++) begin
			// Odd passes hold the strobe and still step once per read
			bus_cycle(RAND_ADDR, 1'b0, 2'b11, 16'h0, (i % 2) * 2, rd, lat);
			check_eq("low half", lfsr_state[15:0], rd);
			lfsr_state = lfsr_model(lfsr_state);
			bus_cycle(RAND_ADDR + 2, 1'b0, 2'b11, 16'h0, 0, rd, lat);
			check_eq("high half", lfsr_state[31:16], rd);
		end
		finish_test();

		// ====================
		// Audio
		// ====================
		start_test("audio");
		for (i = 0; i < 2; i++) begin
			left  = 16'($random(seed));
			right = 16'($random(seed));
			bus_cycle(AUDIO_ADDR + 2, 1'b1, 2'b11, left, 0, rd, lat);
			bus_cycle(AUDIO_ADDR + 4, 1'b1, 2'b11, right, 0, rd, lat);
			bus_cycle(AUDIO_ADDR, 1'b1, 2'b11, 16'h0002, 0, rd, lat);
			check_eq("clock enable", 1, ac_clk_oe_o);
			bus_cycle(AUDIO_ADDR + 2, 1'b0, 2'b11, 16'h0, 0, rd, lat);
			check_eq("left readback", left, rd);
			check_frame(left, right, 1'b1);
		end
		finish_test();

		start_test("audio_off");
		// With receive only the shift word still carries the last samples
		bus_cycle(AUDIO_ADDR, 1'b1, 2'b11, 16'h0001, 0, rd, lat);
		check_eq("clock enable rx", 1, ac_clk_oe_o);
		check_frame(left, right, 1'b0);
		bus_cycle(AUDIO_ADDR, 1'b1, 2'b11, 16'h0000, 0, rd, lat);
		@(negedge cpu_clk);
		check_eq("clock enable off", 0, ac_clk_oe_o);
		check_eq("sdata off", 0, ac_dac_sdata_o);
		finish_test();

		// ====================
		// Unmapped
		// ====================
		start_test("unmapped");
		addr = {8'h00, 24'($random(seed))};
		bus_cycle(addr, 1'b0, 2'b11, 16'h0, 0, rd, lat);
		check_eq("read data", `UNMAPPED_DATA, rd);
		check_eq("ack latency", 1, lat);
		finish_test();

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
